//--- bulk_pkg.sv
package bulk_pkg;

  // Bulk IN sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE     = 2'd0,
    SEQ_STREAM   = 2'd1,  // Data phase
    SEQ_WAIT_HSK = 2'd2   // Waiting for the host ACK
  } seq_state_e;

  // Result codes, high nibble of each log byte
  typedef enum logic [3:0] {
    RES_ACK     = 4'd1,
    RES_TIMEOUT = 4'd2,
    RES_NAK     = 4'd3
  } xfer_result_e;

endpackage

//--- bulk_sequencer.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

module bulk_sequencer (
  input  logic                       clock,
  input  logic                       areset_n,
  input  logic                       core_rst,
  input  logic                       in_req_i,
  input  logic [`USB_ENDP_W-1:0]     in_endp_i,
  input  logic                       user_ready_i,
  input  logic [`TELE_DEPTH_LOG2:0]  tele_level_i,
  input  logic                       last_sent_i,
  input  logic                       hsk_ack_i,
  output logic                       blk_start_o,
  output logic                       blk_cycle_o,
  output logic [`USB_ENDP_W-1:0]     blk_endpt_o,
  output logic                       nak_o,
  output logic                       timeout_o,
  output logic                       log_wr_o,
  output logic [7:0]                 log_code_o
);
  import bulk_pkg::*;

  localparam int CNT_W = $clog2(`HSK_TIMEOUT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`HSK_TIMEOUT - 1);
  localparam logic [`USB_ENDP_W-1:0] EP_USER_ID = `EP_USER;
  localparam logic [`USB_ENDP_W-1:0] EP_TELE_ID = `EP_TELE;

  seq_state_e       state_q;
  logic [CNT_W-1:0] hsk_cnt_q;
  logic             ep_ready;

  // Can the requested endpoint answer with data right now
  always_comb begin
    case (in_endp_i)
      EP_USER_ID: ep_ready = user_ready_i;
      EP_TELE_ID: ep_ready = (tele_level_i != '0);  // Anything logged
      default:    ep_ready = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q     <= SEQ_IDLE;
      hsk_cnt_q   <= '0;
      blk_start_o <= 1'b0;
      blk_cycle_o <= 1'b0;
      blk_endpt_o <= '0;
      nak_o       <= 1'b0;
      timeout_o   <= 1'b0;
      log_wr_o    <= 1'b0;
      log_code_o  <= '0;
    end else if (core_rst) begin
      state_q     <= SEQ_IDLE;
      hsk_cnt_q   <= '0;
      blk_start_o <= 1'b0;
      blk_cycle_o <= 1'b0;
      blk_endpt_o <= '0;
      nak_o       <= 1'b0;
      timeout_o   <= 1'b0;
      log_wr_o    <= 1'b0;
      log_code_o  <= '0;
    end else begin
      blk_start_o <= 1'b0;  // Single-cycle strobes
      nak_o       <= 1'b0;
      timeout_o   <= 1'b0;
      log_wr_o    <= 1'b0;

      case (state_q)
        SEQ_IDLE: begin
          if (in_req_i && ep_ready) begin
            blk_start_o <= 1'b1;
            blk_cycle_o <= 1'b1;
            blk_endpt_o <= in_endp_i;
            state_q     <= SEQ_STREAM;
          end else if (in_req_i) begin
            nak_o      <= 1'b1;
            log_wr_o   <= 1'b1;
            log_code_o <= {RES_NAK, in_endp_i};
          end
        end

        // Handshake timer is held while bytes are still going out
        SEQ_STREAM: begin
          if (last_sent_i) begin
            blk_cycle_o <= 1'b0;
            hsk_cnt_q   <= '0;
            state_q     <= SEQ_WAIT_HSK;
          end
        end

        SEQ_WAIT_HSK: begin
          if (hsk_ack_i) begin
            log_wr_o   <= 1'b1;
            log_code_o <= {RES_ACK, blk_endpt_o};
            state_q    <= SEQ_IDLE;
          end else if (hsk_cnt_q == CNT_LAST) begin
            timeout_o  <= 1'b1;  // Host never answered
            log_wr_o   <= 1'b1;
            log_code_o <= {RES_TIMEOUT, blk_endpt_o};
            state_q    <= SEQ_IDLE;
          end else begin
            hsk_cnt_q <= hsk_cnt_q + 1'b1;
          end
        end

        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

endmodule

//--- byte_stream_if.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

interface byte_stream_if;
  logic                   tvalid;
  logic                   tready;
  logic                   tlast;  // Final byte of the packet
  logic [`USB_DATA_W-1:0] tdata;

  modport source (
    output tvalid, tlast, tdata,
    input  tready
  );

  modport sink (
    input  tvalid, tlast, tdata,
    output tready
  );
endinterface

//--- in_stream_mux.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

module in_stream_mux (
  input  logic                   clock,
  input  logic                   areset_n,
  input  logic                   core_rst,
  input  logic                   blk_cycle_i,
  input  logic [`USB_ENDP_W-1:0] blk_endpt_i,
  byte_stream_if.sink            user_s,
  byte_stream_if.sink            tele_s,
  byte_stream_if.source          tx_m,
  output logic                   last_sent_o
);
  localparam logic [`USB_ENDP_W-1:0] EP_USER_ID = `EP_USER;
  localparam logic [`USB_ENDP_W-1:0] EP_TELE_ID = `EP_TELE;

  logic                   sel_user;
  logic                   sel_tele;
  logic                   in_valid;
  logic                   in_last;
  logic [`USB_DATA_W-1:0] in_data;
  logic                   in_ready;
  logic                   in_fire;
  logic                   out_fire;
  logic                   tail_seen_q;  // tlast already taken this transaction
  logic [`USB_DATA_W:0]   skid_mem [2];  // {tlast, tdata}
  logic [`USB_DATA_W:0]   head;
  logic                   wr_ptr_q;
  logic                   rd_ptr_q;
  logic [1:0]             count_q;

  assign sel_user = blk_cycle_i && !tail_seen_q && (blk_endpt_i == EP_USER_ID);
  assign sel_tele = blk_cycle_i && !tail_seen_q && (blk_endpt_i == EP_TELE_ID);

  always_comb begin
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_data  = '0;
    if (sel_user) begin
      in_valid = user_s.tvalid;
      in_last  = user_s.tlast;
      in_data  = user_s.tdata;
    end else if (sel_tele) begin
      in_valid = tele_s.tvalid;
      in_last  = tele_s.tlast;
      in_data  = tele_s.tdata;
    end
  end

  // Ready comes from the fill count only, never from tx_tready
  assign in_ready      = (count_q != 2'd2);
  assign in_fire       = in_valid && in_ready;
  assign user_s.tready = sel_user && in_ready;
  assign tele_s.tready = sel_tele && in_ready;

  assign head        = skid_mem[rd_ptr_q];
  assign tx_m.tvalid = (count_q != 2'd0);
  assign tx_m.tlast  = head[`USB_DATA_W];
  assign tx_m.tdata  = head[`USB_DATA_W-1:0];
  assign out_fire    = tx_m.tvalid && tx_m.tready;
  assign last_sent_o = out_fire && tx_m.tlast;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      tail_seen_q <= 1'b0;
    end else if (core_rst) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      tail_seen_q <= 1'b0;
    end else begin
      if (in_fire) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (out_fire) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({in_fire, out_fire})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
      if (!blk_cycle_i) begin
        tail_seen_q <= 1'b0;
      end else if (in_fire && in_last) begin
        tail_seen_q <= 1'b1;  // Stop pulling the next packet
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in_fire) begin
      skid_mem[wr_ptr_q] <= {in_last, in_data};
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_usb_bulk_bridge -f sources.f

./obj_dir/Vtb_usb_bulk_bridge > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  exit 1
fi

//--- sources.f
+incdir+.
usb_pkg.sv
bulk_pkg.sv
byte_stream_if.sv
token_decoder.sv
bulk_sequencer.sv
in_stream_mux.sv
telemetry_fifo.sv
usb_bulk_bridge.sv
tb_usb_bulk_bridge.sv

//--- tb_usb_bulk_bridge.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

module tb_usb_bulk_bridge;

  localparam logic [3:0] PID_IN   = 4'b1001;
  localparam logic [3:0] PID_SOF  = 4'b0101;
  localparam logic [6:0] DEV_ADDR = 7'h2C;
  localparam int WAIT_LIMIT = 200;  // Cycles per wait loop

  logic        clock;
  logic        areset_n;
  logic        usb_bus_reset;
  logic [6:0]  dev_addr;
  logic        token_valid;
  logic [3:0]  token_pid;
  logic [10:0] token_payload;
  logic        hsk_ack;
  logic        blk_in_ready;
  logic        s_tvalid;
  logic        s_tlast;
  logic [7:0]  s_tdata;
  logic        s_tready;
  logic        tx_tvalid;
  logic        tx_tlast;
  logic [7:0]  tx_tdata;
  logic        tx_tready;
  logic        blk_start;
  logic        blk_cycle;
  logic [3:0]  blk_endpt;
  logic        nak;
  logic        timeout;
  logic        sof;
  logic [10:0] frame;
  logic        has_telemetry;
  logic        usb_reset;

  int         value_errors;
  int         timeout_errors;
  integer     seed;
  logic [7:0] exp_bytes [$];  // Bytes expected on tx, in order

  usb_bulk_bridge u_usb_bulk_bridge (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_bus_reset_i (usb_bus_reset),
    .dev_addr_i      (dev_addr),
    .token_valid_i   (token_valid),
    .token_pid_i     (token_pid),
    .token_payload_i (token_payload),
    .hsk_ack_i       (hsk_ack),
    .blk_in_ready_i  (blk_in_ready),
    .s_tvalid_i      (s_tvalid),
    .s_tlast_i       (s_tlast),
    .s_tdata_i       (s_tdata),
    .s_tready_o      (s_tready),
    .tx_tvalid_o     (tx_tvalid),
    .tx_tlast_o      (tx_tlast),
    .tx_tdata_o      (tx_tdata),
    .tx_tready_i     (tx_tready),
    .blk_start_o     (blk_start),
    .blk_cycle_o     (blk_cycle),
    .blk_endpt_o     (blk_endpt),
    .nak_o           (nak),
    .timeout_o       (timeout),
    .sof_o           (sof),
    .frame_o         (frame),
    .has_telemetry_o (has_telemetry),
    .usb_reset_o     (usb_reset)
  );

  always #5 clock = ~clock;

  // Inputs change and outputs are read 1 ns after each rising edge
  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  task automatic check_eq(input string test, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
    assert (actual == expected) else begin
      value_errors++;
      $display("** Error [%s] %s: expected 'h%0h, actual 'h%0h", test, what, expected, actual);
    end
  endtask

  task automatic check_done(input string test, input logic done, input string what);
    assert (done) else begin
      timeout_errors++;
      $display("[%s] gave up waiting for %s", test, what);
    end
  endtask

  // Token is sampled on the next edge
  task automatic send_token(input logic [3:0] pid, input logic [10:0] payload);
    token_valid   = 1'b1;
    token_pid     = pid;
    token_payload = payload;
    tick();
    token_valid = 1'b0;
  endtask

  task automatic drive_user_packet(input string test, input logic [7:0] base, input int n);
    int   idx;
    int   cycles;
    logic ready;
    idx    = 0;
    cycles = 0;
    while (idx < n && cycles < WAIT_LIMIT) begin
      s_tvalid = 1'b1;
      s_tdata  = base + 8'(idx);
      s_tlast  = (idx == n - 1);
      ready    = s_tready;  // Registered, so stable here
      tick();
      if (ready) begin
        idx++;
      end
      cycles++;
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    check_done(test, idx == n, "the user stream to be accepted");
  endtask

  task automatic collect_tx(input string test, input logic random_ready);
    int          idx;
    int          cycles;
    logic [31:0] rnd;
    idx    = 0;
    cycles = 0;
    while (idx < exp_bytes.size() && cycles < WAIT_LIMIT) begin
      rnd       = $random(seed);
      tx_tready = random_ready ? rnd[0] : 1'b1;
      if (tx_tvalid && tx_tready) begin  // Beat moves on the next edge
        check_eq(test, "tx_tdata", 32'(exp_bytes[idx]), 32'(tx_tdata));
        check_eq(test, "tx_tlast", 32'(idx == exp_bytes.size() - 1), 32'(tx_tlast));
        idx++;
      end
      tick();
      cycles++;
    end
    tx_tready = 1'b1;
    check_done(test, idx == exp_bytes.size(), "all tx bytes");
    check_eq(test, "tx_tvalid after tlast", 0, 32'(tx_tvalid));  // No extra beats
  endtask

  task automatic pulse_ack(input string test);
    int cycles;
    cycles  = 0;
    hsk_ack = 1'b1;
    tick();
    hsk_ack = 1'b0;
    check_eq(test, "blk_cycle_o after ack", 0, 32'(blk_cycle));
    while (!timeout && cycles < `HSK_TIMEOUT + 4) begin  // Ack must stop the timer
      tick();
      cycles++;
    end
    check_eq(test, "timeout_o after ack", 0, 32'(timeout));
  endtask

  // Endpoint 1 IN with 8 bytes from base upward
  task automatic user_in_xfer(input string test, input logic [7:0] base,
                              input logic give_ack, input logic random_ready);
    send_token(PID_IN, {4'd1, DEV_ADDR});
    check_eq(test, "blk_start_o 1 cycle after token", 0, 32'(blk_start));
    tick();
    check_eq(test, "blk_start_o 2 cycles after token", 1, 32'(blk_start));
    check_eq(test, "blk_cycle_o with blk_start_o", 1, 32'(blk_cycle));
    check_eq(test, "blk_endpt_o", `EP_USER, 32'(blk_endpt));
    exp_bytes.delete();
    for (int i = 0; i < 8; i++) begin
      exp_bytes.push_back(base + 8'(i));
    end
    fork
      drive_user_packet(test, base, 8);
      collect_tx(test, random_ready);
    join
    if (give_ack) begin
      pulse_ack(test);
    end
  endtask

  task automatic test_nak_and_filter();
    int hits;
    hits = 0;
    blk_in_ready = 1'b0;
    send_token(PID_IN, {4'd1, DEV_ADDR});
    check_eq("nak", "nak_o 1 cycle after token", 0, 32'(nak));
    tick();
    check_eq("nak", "nak_o 2 cycles after token", 1, 32'(nak));
    check_eq("nak", "blk_start_o", 0, 32'(blk_start));
    tick();
    blk_in_ready = 1'b1;
    send_token(PID_IN, {4'd1, DEV_ADDR ^ 7'h01});  // Someone else's address
    repeat (4) begin
      if (blk_start || nak) begin
        hits++;
      end
      tick();
    end
    check_eq("addr_filter", "start or nak pulses", 0, 32'(hits));
  endtask

  task automatic test_timeout();
    int cycles;
    cycles = 0;
    user_in_xfer("timeout", 8'h50, 1'b0, 1'b0);
    while (!timeout && cycles < `HSK_TIMEOUT + 4) begin  // Counted from the tlast edge
      tick();
      cycles++;
    end
    check_done("timeout", timeout, "the handshake timeout pulse");
    assert (cycles >= `HSK_TIMEOUT) else begin
      value_errors++;
      $display("** Error [timeout] timeout_o delay: expected at least %0d cycles, actual %0d",
               `HSK_TIMEOUT, cycles);
    end
    tick();
    check_eq("timeout", "timeout_o one cycle later", 0, 32'(timeout));
  endtask

  task automatic test_sof();
    send_token(PID_SOF, 11'h5A3);  // Address field does not match
    check_eq("sof", "sof_o", 1, 32'(sof));
    check_eq("sof", "frame_o", 32'h5A3, 32'(frame));
    tick();
    check_eq("sof", "sof_o one cycle later", 0, 32'(sof));
  endtask

  task automatic test_telemetry();
    tick();  // Last log write reaches the level
    check_eq("telemetry", "has_telemetry_o", 1, 32'(has_telemetry));
    send_token(PID_IN, {4'd2, DEV_ADDR});
    tick();
    check_eq("telemetry", "blk_start_o", 1, 32'(blk_start));
    check_eq("telemetry", "blk_endpt_o", `EP_TELE, 32'(blk_endpt));
    exp_bytes.delete();
    exp_bytes.push_back(8'h11);  // Ack, endpoint 1
    exp_bytes.push_back(8'h31);  // NAK
    exp_bytes.push_back(8'h21);  // Timeout
    exp_bytes.push_back(8'h11);
    collect_tx("telemetry", 1'b0);
    pulse_ack("telemetry");
  endtask

  initial begin
    int cycles;
    clock         = 1'b0;
    areset_n      = 1'b0;
    usb_bus_reset = 1'b0;
    dev_addr      = DEV_ADDR;
    token_valid   = 1'b0;
    token_pid     = 4'h0;
    token_payload = 11'h000;
    hsk_ack       = 1'b0;
    blk_in_ready  = 1'b1;
    s_tvalid      = 1'b0;
    s_tlast       = 1'b0;
    s_tdata       = 8'h00;
    tx_tready     = 1'b1;
    seed          = 32'h1465;
    value_errors   = 0;
    timeout_errors = 0;

    repeat (8) @(posedge clock);
    #1;
    areset_n = 1'b1;
    cycles   = 0;
    while (usb_reset && cycles < WAIT_LIMIT) begin  // Synchronizer release
      tick();
      cycles++;
    end
    check_done("reset", !usb_reset, "core reset release");
    check_eq("reset", "status outputs",
             0, 32'({blk_start, blk_cycle, nak, timeout, sof, tx_tvalid, has_telemetry}));

    user_in_xfer("user_in", 8'hA0, 1'b1, 1'b0);
    test_nak_and_filter();
    test_timeout();
    test_sof();
    // Back-pressure first, so the log holds four entries
    user_in_xfer("backpressure", 8'h30, 1'b1, 1'b1);
    test_telemetry();

    $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- telemetry_fifo.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

module telemetry_fifo (
  input  logic                      clock,
  input  logic                      areset_n,
  input  logic                      core_rst,
  input  logic                      log_wr_i,
  input  logic [7:0]                log_code_i,
  input  logic                      blk_start_i,
  input  logic [`USB_ENDP_W-1:0]    blk_endpt_i,
  byte_stream_if.source             tele_m,
  output logic [`TELE_DEPTH_LOG2:0] level_o,
  output logic                      has_telemetry_o
);
  localparam int DEPTH = 1 << `TELE_DEPTH_LOG2;
  localparam int LVL_W = `TELE_DEPTH_LOG2 + 1;
  localparam logic [`USB_ENDP_W-1:0] EP_TELE_ID = `EP_TELE;

  logic [`USB_DATA_W-1:0] mem [DEPTH];
  logic [LVL_W-1:0]       wr_ptr_q;  // Extra bit tells full from empty
  logic [LVL_W-1:0]       rd_ptr_q;
  logic [LVL_W-1:0]       remain_q;  // Bytes left in the current packet
  logic                   active_q;
  logic                   full;
  logic                   wr_en;
  logic                   rd_en;

  assign level_o         = wr_ptr_q - rd_ptr_q;
  assign full            = (level_o == LVL_W'(DEPTH));
  assign wr_en           = log_wr_i && !full;  // Dropped when full
  assign has_telemetry_o = (level_o >= LVL_W'(`TELE_REPORT_LEVEL));

  // Only streams inside an endpoint 2 transaction
  assign tele_m.tvalid = active_q && (level_o != '0);
  assign tele_m.tdata  = mem[rd_ptr_q[`TELE_DEPTH_LOG2-1:0]];
  assign tele_m.tlast  = (remain_q == LVL_W'(1));
  assign rd_en         = tele_m.tvalid && tele_m.tready;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      remain_q <= '0;
      active_q <= 1'b0;
    end else if (core_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      remain_q <= '0;
      active_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      // Packet length is whatever is logged at the start
      if (blk_start_i && (blk_endpt_i == EP_TELE_ID)) begin
        remain_q <= level_o;
        active_q <= (level_o != '0);
      end else if (rd_en) begin
        remain_q <= remain_q - 1'b1;
        if (tele_m.tlast) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr_q[`TELE_DEPTH_LOG2-1:0]] <= log_code_i;
    end
  end

endmodule

//--- token_decoder.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

module token_decoder (
  input  logic                    clock,
  input  logic                    areset_n,
  input  logic                    core_rst,
  input  logic                    token_valid_i,
  input  usb_pkg::token_pid_e     token_pid_i,
  input  usb_pkg::token_payload_u token_payload_i,
  input  logic [`USB_ADDR_W-1:0]  dev_addr_i,
  output logic                    in_req_o,
  output logic [`USB_ENDP_W-1:0]  in_endp_o,
  output logic                    sof_o,
  output logic [10:0]             frame_o
);
  import usb_pkg::*;

  logic is_in;
  logic is_sof;
  logic addr_hit;

  assign is_in    = token_valid_i && (token_pid_i == TOK_IN);
  assign is_sof   = token_valid_i && (token_pid_i == TOK_SOF);
  assign addr_hit = (token_payload_i.ep.addr == dev_addr_i);  // Endpoint view

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      in_req_o <= 1'b0;
      sof_o    <= 1'b0;
    end else if (core_rst) begin
      in_req_o <= 1'b0;
      sof_o    <= 1'b0;
    end else begin
      in_req_o <= is_in && addr_hit;
      sof_o    <= is_sof;  // SOF is broadcast
    end
  end

  // Token fields, held until the next token of the same kind
  always_ff @(posedge clock) begin
    if (is_in) begin
      in_endp_o <= token_payload_i.ep.endp;
    end
    if (is_sof) begin
      frame_o <= token_payload_i.frame;  // Frame view
    end
  end

endmodule

//--- usb_bulk_bridge.sv
`timescale 1ns/1ps
`include "usb_bulk_defs.svh"

module usb_bulk_bridge (
  input  logic                               clock,
  input  logic                               areset_n,
  input  logic                               usb_bus_reset_i,
  input  logic [`USB_ADDR_W-1:0]             dev_addr_i,
  input  logic                               token_valid_i,
  input  logic [3:0]                         token_pid_i,
  input  logic [`USB_ENDP_W+`USB_ADDR_W-1:0] token_payload_i,
  input  logic                               hsk_ack_i,
  input  logic                               blk_in_ready_i,
  input  logic                               s_tvalid_i,
  input  logic                               s_tlast_i,
  input  logic [`USB_DATA_W-1:0]             s_tdata_i,
  output logic                               s_tready_o,
  output logic                               tx_tvalid_o,
  output logic                               tx_tlast_o,
  output logic [`USB_DATA_W-1:0]             tx_tdata_o,
  input  logic                               tx_tready_i,
  output logic                               blk_start_o,
  output logic                               blk_cycle_o,
  output logic [`USB_ENDP_W-1:0]             blk_endpt_o,
  output logic                               nak_o,
  output logic                               timeout_o,
  output logic                               sof_o,
  output logic [10:0]                        frame_o,
  output logic                               has_telemetry_o,
  output logic                               usb_reset_o
);
  import usb_pkg::*;

  logic [2:0]                rst_sync_q;
  logic                      core_rst;
  token_pid_e                token_pid;
  token_payload_u            token_payload;
  logic                      in_req;
  logic [`USB_ENDP_W-1:0]    in_endp;
  logic                      last_sent;
  logic                      log_wr;
  logic [7:0]                log_code;
  logic [`TELE_DEPTH_LOG2:0] tele_level;

  byte_stream_if user_if ();
  byte_stream_if tele_if ();
  byte_stream_if tx_if ();

  // Three-stage reset release, bus reset clears the last stage
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_sync_q <= 3'b000;
    end else begin
      rst_sync_q <= {rst_sync_q[1] & ~usb_bus_reset_i, rst_sync_q[0], 1'b1};
    end
  end

  assign core_rst    = ~rst_sync_q[2];
  assign usb_reset_o = core_rst;

  assign token_pid     = token_pid_e'(token_pid_i);
  assign token_payload = token_payload_i;

  // Endpoint 1 user stream
  assign user_if.tvalid = s_tvalid_i;
  assign user_if.tlast  = s_tlast_i;
  assign user_if.tdata  = s_tdata_i;
  assign s_tready_o     = user_if.tready;

  assign tx_tvalid_o  = tx_if.tvalid;
  assign tx_tlast_o   = tx_if.tlast;
  assign tx_tdata_o   = tx_if.tdata;
  assign tx_if.tready = tx_tready_i;

  token_decoder u_token_decoder (
    .clock           (clock),
    .areset_n        (areset_n),
    .core_rst        (core_rst),
    .token_valid_i   (token_valid_i),
    .token_pid_i     (token_pid),
    .token_payload_i (token_payload),
    .dev_addr_i      (dev_addr_i),
    .in_req_o        (in_req),
    .in_endp_o       (in_endp),
    .sof_o           (sof_o),
    .frame_o         (frame_o)
  );

  bulk_sequencer u_bulk_sequencer (
    .clock        (clock),
    .areset_n     (areset_n),
    .core_rst     (core_rst),
    .in_req_i     (in_req),
    .in_endp_i    (in_endp),
    .user_ready_i (blk_in_ready_i),
    .tele_level_i (tele_level),
    .last_sent_i  (last_sent),
    .hsk_ack_i    (hsk_ack_i),
    .blk_start_o  (blk_start_o),
    .blk_cycle_o  (blk_cycle_o),
    .blk_endpt_o  (blk_endpt_o),
    .nak_o        (nak_o),
    .timeout_o    (timeout_o),
    .log_wr_o     (log_wr),
    .log_code_o   (log_code)
  );

  in_stream_mux u_in_stream_mux (
    .clock       (clock),
    .areset_n    (areset_n),
    .core_rst    (core_rst),
    .blk_cycle_i (blk_cycle_o),
    .blk_endpt_i (blk_endpt_o),
    .user_s      (user_if.sink),
    .tele_s      (tele_if.sink),
    .tx_m        (tx_if.source),
    .last_sent_o (last_sent)
  );

  telemetry_fifo u_telemetry_fifo (
    .clock           (clock),
    .areset_n        (areset_n),
    .core_rst        (core_rst),
    .log_wr_i        (log_wr),
    .log_code_i      (log_code),
    .blk_start_i     (blk_start_o),
    .blk_endpt_i     (blk_endpt_o),
    .tele_m          (tele_if.source),
    .level_o         (tele_level),
    .has_telemetry_o (has_telemetry_o)
  );

endmodule

//--- usb_bulk_defs.svh
`ifndef USB_BULK_DEFS_SVH
`define USB_BULK_DEFS_SVH

// Stream and token field widths
`define USB_DATA_W 8
`define USB_ADDR_W 7
`define USB_ENDP_W 4

// Bulk IN endpoint numbers
`define EP_USER 1
`define EP_TELE 2  // Bridge's own result log

// Telemetry log, 2**4 entries
`define TELE_DEPTH_LOG2 4

// Level that raises has_telemetry
`define TELE_REPORT_LEVEL 4

// Cycles allowed for the host ACK
`define HSK_TIMEOUT 64

`endif

//--- usb_pkg.sv
`include "usb_bulk_defs.svh"

package usb_pkg;

  // Token PIDs, low nibble of the PID byte
  typedef enum logic [3:0] {
    TOK_OUT   = 4'b0001,
    TOK_IN    = 4'b1001,
    TOK_SOF   = 4'b0101,
    TOK_SETUP = 4'b1101
  } token_pid_e;

  // 11-bit token payload
  // IN/OUT/SETUP carry endpoint and address, SOF carries the frame number
  typedef union packed {
    struct packed {
      logic [`USB_ENDP_W-1:0] endp;
      logic [`USB_ADDR_W-1:0] addr;
    } ep;
    logic [`USB_ENDP_W+`USB_ADDR_W-1:0] frame;
  } token_payload_u;

endpackage
